/* Bender.yml */
package:
  name: wisc_core

sources:
  - include_dirs:
      - .
    files:
      - isaPkg.sv
      - ctrlPkg.sv
      - regFile.sv
      - decode.sv
      - stageReg.sv
      - execute.sv
      - writeback.sv
      - cpuCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbChecker.sv
      - tbCore.sv

/* cpuCore.sv */
// accepts one instr per cycle with no back-pressure and retires each exactly two edges after sampling
`default_nettype none
`timescale 1ns/1ns

`include "wiscCore_defines.svh"

module cpuCore (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`WORD_WIDTH-1:0]    instr,
   input  logic                      instrValid,
   output logic                      retireValid,
   output logic                      retireIllegal,
   output logic                      retireWrite,
   output logic [`REG_SEL_WIDTH-1:0] retireReg,
   output logic [`WORD_WIDTH-1:0]    retireData
);

   logic [`REG_SEL_WIDTH-1:0] read1Sel;
   logic [`REG_SEL_WIDTH-1:0] read2Sel;
   logic [`WORD_WIDTH-1:0]    read1Data;
   logic [`WORD_WIDTH-1:0]    read2Data;
   logic                      writeEn;
   logic [`REG_SEL_WIDTH-1:0] writeSel;
   logic [`WORD_WIDTH-1:0]    writeData;
   ctrlPkg::decodeOut_t       decoded;
   ctrlPkg::decodeOut_t       exStage; // stage one
   logic                      exValid;
   ctrlPkg::result_t          exResult;
   ctrlPkg::result_t          wbStage; // stage two
   logic                      wbValid;

   decode iDecode (.instr(instr), .read1Sel(read1Sel), .read2Sel(read2Sel),
                   .read1Data(read1Data), .read2Data(read2Data), .decoded(decoded));

   regFile iRegFile (.clk(clk), .rst(rst), .read1Sel(read1Sel), .read2Sel(read2Sel),
                     .writeEn(writeEn), .writeSel(writeSel), .writeData(writeData),
                     .read1Data(read1Data), .read2Data(read2Data));

   stageReg #(.T(ctrlPkg::decodeOut_t)) iExReg (.clk(clk), .rst(rst), .validIn(instrValid),
      .dataIn(decoded), .validOut(exValid), .dataOut(exStage));

   // stage two feeds back into execute for the distance-one case
   execute iExecute (.stageIn(exStage), .fwdValid(wbValid), .fwd(wbStage), .result(exResult));

   stageReg #(.T(ctrlPkg::result_t)) iWbReg (.clk(clk), .rst(rst), .validIn(exValid),
      .dataIn(exResult), .validOut(wbValid), .dataOut(wbStage));

   writeback iWriteback (.stageValid(wbValid), .stageIn(wbStage), .writeEn(writeEn),
                         .writeSel(writeSel), .writeData(writeData),
                         .retireValid(retireValid), .retireIllegal(retireIllegal),
                         .retireWrite(retireWrite), .retireReg(retireReg),
                         .retireData(retireData));

endmodule

`default_nettype wire

/* ctrlPkg.sv */
// payloads carried between the three steps and the selects inside them assume WORD_WIDTH >= 16
`default_nettype none

`include "wiscCore_defines.svh"

package ctrlPkg;

   // what execute does with opA and opB
   typedef enum logic [3:0] {
      aluAdd, // a + b
      aluSub, // b - a so SUB and SUBI share it
      aluXor,
      aluAndn, // a & ~b
      aluSeq,
      aluSlt, // signed compare
      aluSle,
      aluBtr, // reverse a
      aluPassB, // LBI
      aluSlbi // (a << 8) | b
   } aluOp_e;

   // source of the B operand
   typedef enum logic [1:0] {
      srcReg,
      srcImm5Sext,
      srcImm5Zext,
      srcImm8 // extension picked by opcode
   } aluSrc_e;

   typedef struct packed {
      aluOp_e  aluOp;
      aluSrc_e aluSrc;
      logic    regWrite;
      logic    illegal; // opcode outside the subset
   } ctrl_t;

   // decode -> execute
   typedef struct packed {
      ctrl_t                     ctrl;
      logic [`REG_SEL_WIDTH-1:0] read1Sel; // kept for forwarding compares
      logic [`REG_SEL_WIDTH-1:0] read2Sel;
      logic [`WORD_WIDTH-1:0]    read1Data;
      logic [`WORD_WIDTH-1:0]    read2Data;
      logic [`WORD_WIDTH-1:0]    immB; // B as decode saw it
      logic [`REG_SEL_WIDTH-1:0] destSel;
   } decodeOut_t;

   // execute -> result step
   typedef struct packed {
      logic                      regWrite;
      logic                      illegal;
      logic [`REG_SEL_WIDTH-1:0] destSel;
      logic [`WORD_WIDTH-1:0]    value;
   } result_t;

endpackage

`default_nettype wire

/* decode.sv */
// purely combinational and reads rs and rt from fixed fields before the format is known
`default_nettype none
`timescale 1ns/1ns

`include "wiscCore_defines.svh"

module decode (
   input  logic [`WORD_WIDTH-1:0]    instr,
   output logic [`REG_SEL_WIDTH-1:0] read1Sel,
   output logic [`REG_SEL_WIDTH-1:0] read2Sel,
   input  logic [`WORD_WIDTH-1:0]    read1Data,
   input  logic [`WORD_WIDTH-1:0]    read2Data,
   output ctrlPkg::decodeOut_t       decoded
);

   isaPkg::opcode_e              opcode;
   isaPkg::funct_e               funct;
   logic [`REG_SEL_WIDTH-1:0]    rs;
   logic [`REG_SEL_WIDTH-1:0]    rt;
   logic [`REG_SEL_WIDTH-1:0]    rd;
   logic [isaPkg::imm5Width-1:0] imm5;
   logic [isaPkg::imm8Width-1:0] imm8;
   ctrlPkg::ctrl_t               decCtrl;
   logic [`REG_SEL_WIDTH-1:0]    destSel;
   logic [`WORD_WIDTH-1:0]       imm5Ext;
   logic [`WORD_WIDTH-1:0]       imm8Ext;
   logic [`WORD_WIDTH-1:0]       immB;

   // field slicing
   assign opcode = isaPkg::opcode_e'(instr[isaPkg::opcodeLsb +: isaPkg::opcodeWidth]);
   assign funct  = isaPkg::funct_e'(instr[isaPkg::functWidth-1:0]);
   assign rs     = instr[isaPkg::rsLsb +: `REG_SEL_WIDTH];
   assign rt     = instr[isaPkg::rtLsb +: `REG_SEL_WIDTH];
   assign rd     = instr[isaPkg::rdLsb +: `REG_SEL_WIDTH];
   assign imm5   = instr[isaPkg::imm5Width-1:0];
   assign imm8   = instr[isaPkg::imm8Width-1:0];

   assign read1Sel = rs; // SLBI reads its own destination here
   assign read2Sel = rt; // unused by immediate forms but harmless

   // control and destination per opcode
   always_comb begin
      decCtrl = '{aluOp: ctrlPkg::aluPassB, aluSrc: ctrlPkg::srcReg,
                  regWrite: 1'b0, illegal: 1'b0};
      destSel = rd; // RR, set-if, BTR
      case (opcode)
         isaPkg::opNop: decCtrl.regWrite = 1'b0;
         isaPkg::opAddi, isaPkg::opSubi: begin
            decCtrl.aluOp    = (opcode == isaPkg::opAddi) ? ctrlPkg::aluAdd : ctrlPkg::aluSub;
            decCtrl.aluSrc   = ctrlPkg::srcImm5Sext;
            decCtrl.regWrite = 1'b1;
            destSel          = rt;
         end
         isaPkg::opXori, isaPkg::opAndni: begin
            decCtrl.aluOp    = (opcode == isaPkg::opXori) ? ctrlPkg::aluXor : ctrlPkg::aluAndn;
            decCtrl.aluSrc   = ctrlPkg::srcImm5Zext;
            decCtrl.regWrite = 1'b1;
            destSel          = rt;
         end
         isaPkg::opLbi, isaPkg::opSlbi: begin
            decCtrl.aluOp    = (opcode == isaPkg::opLbi) ? ctrlPkg::aluPassB : ctrlPkg::aluSlbi;
            decCtrl.aluSrc   = ctrlPkg::srcImm8;
            decCtrl.regWrite = 1'b1;
            destSel          = rs; // LBI format writes rs
         end
         isaPkg::opBtr: begin
            decCtrl.aluOp    = ctrlPkg::aluBtr;
            decCtrl.regWrite = 1'b1;
         end
         isaPkg::opRr: begin
            decCtrl.regWrite = 1'b1;
            case (funct)
               isaPkg::fnAdd: decCtrl.aluOp = ctrlPkg::aluAdd;
               isaPkg::fnSub: decCtrl.aluOp = ctrlPkg::aluSub;
               isaPkg::fnXor: decCtrl.aluOp = ctrlPkg::aluXor;
               isaPkg::fnAndn: decCtrl.aluOp = ctrlPkg::aluAndn;
            endcase
         end
         isaPkg::opSeq: begin
            decCtrl.aluOp    = ctrlPkg::aluSeq;
            decCtrl.regWrite = 1'b1;
         end
         isaPkg::opSlt: begin
            decCtrl.aluOp    = ctrlPkg::aluSlt;
            decCtrl.regWrite = 1'b1;
         end
         isaPkg::opSle: begin
            decCtrl.aluOp    = ctrlPkg::aluSle;
            decCtrl.regWrite = 1'b1;
         end
         default: decCtrl.illegal = 1'b1; // retires as a flagged no-op
      endcase
   end

   // XORI and ANDNI zero extend, ADDI and SUBI sign extend
   assign imm5Ext = (decCtrl.aluSrc == ctrlPkg::srcImm5Zext) ?
                    {{(`WORD_WIDTH-isaPkg::imm5Width){1'b0}}, imm5} :
                    {{(`WORD_WIDTH-isaPkg::imm5Width){imm5[isaPkg::imm5Width-1]}}, imm5};
   assign imm8Ext = (decCtrl.aluOp == ctrlPkg::aluSlbi) ?
                    {{(`WORD_WIDTH-isaPkg::imm8Width){1'b0}}, imm8} : // or-ed in low byte
                    {{(`WORD_WIDTH-isaPkg::imm8Width){imm8[isaPkg::imm8Width-1]}}, imm8};

   always_comb begin
      case (decCtrl.aluSrc)
         ctrlPkg::srcImm5Sext, ctrlPkg::srcImm5Zext: immB = imm5Ext;
         ctrlPkg::srcImm8: immB = imm8Ext;
         default: immB = read2Data; // execute may still override by forwarding
      endcase
   end

   assign decoded = '{ctrl: decCtrl, read1Sel: rs, read2Sel: rt, read1Data: read1Data,
                      read2Data: read2Data, immB: immB, destSel: destSel};

endmodule

`default_nettype wire

/* execute.sv */
// combinational and forwards only from the result step since older values reach decode through the register file
`default_nettype none
`timescale 1ns/1ns

`include "wiscCore_defines.svh"

module execute (
   input  ctrlPkg::decodeOut_t stageIn,
   input  logic                fwdValid,
   input  ctrlPkg::result_t    fwd,
   output ctrlPkg::result_t    result
);

   logic                   fwdLive;
   logic                   fwdHit1;
   logic                   fwdHit2;
   logic [`WORD_WIDTH-1:0] opA;
   logic [`WORD_WIDTH-1:0] regB;
   logic [`WORD_WIDTH-1:0] opB;
   logic [`WORD_WIDTH-1:0] reversedA;
   logic [`WORD_WIDTH-1:0] aluOut;

   // the previous instr sits in stage two and has not committed yet
   assign fwdLive = fwdValid && fwd.regWrite;
   assign fwdHit1 = fwdLive && (fwd.destSel == stageIn.read1Sel);
   assign fwdHit2 = fwdLive && (fwd.destSel == stageIn.read2Sel);

   assign opA  = fwdHit1 ? fwd.value : stageIn.read1Data;
   assign regB = fwdHit2 ? fwd.value : stageIn.read2Data;
   assign opB  = (stageIn.ctrl.aluSrc == ctrlPkg::srcReg) ? regB : stageIn.immB; // imm never forwarded

   // BTR
   always_comb begin
      for (int i = 0; i < `WORD_WIDTH; i++) begin
         reversedA[i] = opA[`WORD_WIDTH-1-i];
      end
   end

   always_comb begin
      case (stageIn.ctrl.aluOp)
         ctrlPkg::aluAdd:   aluOut = opA + opB;
         ctrlPkg::aluSub:   aluOut = opB - opA; // rt - rs or imm - rs
         ctrlPkg::aluXor:   aluOut = opA ^ opB;
         ctrlPkg::aluAndn:  aluOut = opA & ~opB;
         ctrlPkg::aluSeq:   aluOut = {{(`WORD_WIDTH-1){1'b0}}, opA == opB};
         ctrlPkg::aluSlt:   aluOut = {{(`WORD_WIDTH-1){1'b0}}, $signed(opA) < $signed(opB)};
         ctrlPkg::aluSle:   aluOut = {{(`WORD_WIDTH-1){1'b0}}, $signed(opA) <= $signed(opB)};
         ctrlPkg::aluBtr:   aluOut = reversedA;
         ctrlPkg::aluSlbi:  aluOut = (opA << isaPkg::imm8Width) | opB; // opB zero extended
         default:           aluOut = opB; // LBI, sign extended by decode
      endcase
   end

   // non-writing instrs retire with zero data
   assign result = '{regWrite: stageIn.ctrl.regWrite, illegal: stageIn.ctrl.illegal,
                     destSel: stageIn.destSel,
                     value: stageIn.ctrl.regWrite ? aluOut : '0};

endmodule

`default_nettype wire

/* isaPkg.sv */
// encoding of the kept ISA subset only and any opcode missing from opcode_e decodes as illegal
`default_nettype none

package isaPkg;

   // major opcode in instr[15:11]
   typedef enum logic [4:0] {
      opNop  = 5'b00001,
      opAddi = 5'b01000, // rt <- rs + sext(imm5)
      opSubi = 5'b01001, // rt <- sext(imm5) - rs
      opXori = 5'b01010, // zext(imm5)
      opAndni = 5'b01011, // zext(imm5)
      opSlbi = 5'b10010, // rs <- (rs << 8) | zext(imm8)
      opLbi  = 5'b11000, // rs <- sext(imm8)
      opBtr  = 5'b11001, // rd <- bit reversed rs
      opRr   = 5'b11011, // register-register group, op in funct
      opSeq  = 5'b11100,
      opSlt  = 5'b11101,
      opSle  = 5'b11110
   } opcode_e;

   // low two bits of an RR instruction
   typedef enum logic [1:0] {
      fnAdd  = 2'b00,
      fnSub  = 2'b01, // rt - rs
      fnXor  = 2'b10,
      fnAndn = 2'b11 // rs & ~rt
   } funct_e;

   // field positions shared by all formats
   localparam int opcodeLsb = 11;
   localparam int opcodeWidth = 5;
   localparam int rsLsb = 8;
   localparam int rtLsb = 5; // doubles as rd of the immediate forms
   localparam int rdLsb = 2; // rd of RR, set-if and BTR
   localparam int functWidth = 2; // funct sits at bit 0

   // immediates are right aligned at bit 0
   localparam int imm5Width = 5;
   localparam int imm8Width = 8;

endpackage

`default_nettype wire

/* project.f */
+incdir+.
isaPkg.sv
ctrlPkg.sv
regFile.sv
decode.sv
stageReg.sv
execute.sv
writeback.sv
cpuCore.sv
tbChecker.sv
tbCore.sv

/* regFile.sv */
// eight registers cleared by reset and a read of the register being written returns the new value
`default_nettype none
`timescale 1ns/1ns

`include "wiscCore_defines.svh"

module regFile (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`REG_SEL_WIDTH-1:0] read1Sel,
   input  logic [`REG_SEL_WIDTH-1:0] read2Sel,
   input  logic                      writeEn,
   input  logic [`REG_SEL_WIDTH-1:0] writeSel,
   input  logic [`WORD_WIDTH-1:0]    writeData,
   output logic [`WORD_WIDTH-1:0]    read1Data,
   output logic [`WORD_WIDTH-1:0]    read2Data
);

   logic [`WORD_WIDTH-1:0] regs [`NUM_REGS]; // architectural state
   logic                   bypass1;
   logic                   bypass2;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData; // commit from the result step
      end
   end

   // the instr two ahead commits at the same edge this one is sampled
   assign bypass1 = writeEn && (writeSel == read1Sel);
   assign bypass2 = writeEn && (writeSel == read2Sel);

   assign read1Data = bypass1 ? writeData : regs[read1Sel];
   assign read2Data = bypass2 ? writeData : regs[read2Sel];

   // an X select on a write would corrupt every register at once
   writeSelKnown: assert property (@(posedge clk) disable iff (rst)
      writeEn |-> !$isunknown(writeSel))
      else $error("register write with unknown select");

endmodule

`default_nettype wire

/* stageReg.sv */
// one-cycle pipeline register for any payload T and the payload is only meaningful while validOut is high
`default_nettype none
`timescale 1ns/1ns

module stageReg #(
   parameter type T = logic
) (
   input  logic clk,
   input  logic rst,
   input  logic validIn,
   input  T     dataIn,
   output logic validOut,
   output T     dataOut
);

   // valid is control state and clears on reset
   always_ff @(posedge clk) begin
      if (rst) begin
         validOut <= 1'b0;
      end else begin
         validOut <= validIn;
      end
   end

   always_ff @(posedge clk) begin
      dataOut <= dataIn; // loads every cycle, bubbles included
   end

   // an X valid would let garbage retire or write the register file
   validKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(validOut))
      else $error("stage valid unknown after reset");

endmodule

`default_nettype wire

/* tbChecker.sv */
// in-order reference model of the kept ISA, assumes registers clear on reset and a fixed two-edge latency
`default_nettype none
`timescale 1ns/1ns

`include "wiscCore_defines.svh"

module tbChecker (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`WORD_WIDTH-1:0]    instr,
   input  logic                      instrValid,
   input  logic                      retireValid,
   input  logic                      retireIllegal,
   input  logic                      retireWrite,
   input  logic [`REG_SEL_WIDTH-1:0] retireReg,
   input  logic [`WORD_WIDTH-1:0]    retireData,
   output int                        errorCount,
   output int                        checkCount,
   output int                        pendingCount
);

   typedef struct packed {
      logic [`WORD_WIDTH-1:0]    word; // the instr itself, for messages
      logic                      illegal;
      logic                      write;
      logic [`REG_SEL_WIDTH-1:0] dest;
      logic [`WORD_WIDTH-1:0]    data;
      logic [31:0]               cycle; // edge count when sampled
   } expect_t;

   expect_t                expQ [$]; // in flight, oldest first
   logic [`WORD_WIDTH-1:0] model [`NUM_REGS]; // architectural registers in issue order
   int                     cycleCount = 0;

   // expected retire of one instr, a is the rs value and b the rt value
   function automatic expect_t refRetire(input logic [15:0] ins, input logic [15:0] a,
                                         input logic [15:0] b);
      expect_t     e;
      logic [15:0] sImm5;
      logic [15:0] zImm5;
      e = '{word: ins, illegal: 1'b0, write: 1'b1, dest: ins[4:2], data: '0, cycle: '0};
      sImm5 = {{11{ins[4]}}, ins[4:0]};
      zImm5 = {11'b0, ins[4:0]};
      case (ins[15:11])
         5'b00001: e.write = 1'b0; // NOP
         5'b01000: {e.dest, e.data} = {ins[7:5], a + sImm5};
         5'b01001: {e.dest, e.data} = {ins[7:5], sImm5 - a}; // imm minus rs
         5'b01010: {e.dest, e.data} = {ins[7:5], a ^ zImm5};
         5'b01011: {e.dest, e.data} = {ins[7:5], a & ~zImm5};
         5'b10010: {e.dest, e.data} = {ins[10:8], a[7:0], ins[7:0]}; // shift left 8, or imm
         5'b11000: {e.dest, e.data} = {ins[10:8], {8{ins[7]}}, ins[7:0]};
         5'b11001: for (int i = 0; i < 16; i++) begin
            e.data[i] = a[15-i]; // bit reverse
         end
         5'b11011: begin
            case (ins[1:0])
               2'b00: e.data = a + b;
               2'b01: e.data = b - a; // rt minus rs
               2'b10: e.data = a ^ b;
               2'b11: e.data = a & ~b;
            endcase
         end
         5'b11100: e.data = 16'(a == b);
         5'b11101: e.data = 16'($signed(a) < $signed(b));
         5'b11110: e.data = 16'($signed(a) <= $signed(b));
         default: {e.illegal, e.write} = 2'b10; // flagged no-op
      endcase
      return e;
   endfunction

   task automatic mismatch(input string msg);
      errorCount++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   // issue side, same edge the DUT samples on
   always @(posedge clk) begin
      expect_t want;
      if (rst) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            model[i] = '0;
         end
         expQ.delete();
         pendingCount = 0;
      end else if (instrValid === 1'b1) begin
         want = refRetire(instr, model[instr[10:8]], model[instr[7:5]]);
         want.cycle = cycleCount;
         if (want.write)
            model[want.dest] = want.data; // later instrs see it at once
         expQ.push_back(want);
         pendingCount = expQ.size();
      end
      cycleCount++;
   end

   // retire outputs settle after the rising edge, read them mid cycle
   always @(negedge clk) begin
      expect_t want;
      if (!rst && $isunknown(retireValid)) begin
         errorCount++;
         $display("retireValid is unknown at %0t after reset", $time);
      end else if (retireValid === 1'b1 && (rst || expQ.size() == 0)) begin
         errorCount++;
         $display("unexpected retire at %0t with no instruction in flight", $time);
      end else if (retireValid === 1'b1) begin
         want = expQ.pop_front();
         pendingCount = expQ.size();
         checkCount++;
         if (cycleCount != want.cycle + 2)
            mismatch($sformatf("instr %h retired %0d edges after issue, want 2", want.word,
                               cycleCount - want.cycle));
         if ({retireIllegal, retireWrite} !== {want.illegal, want.write})
            mismatch($sformatf("instr %h illegal/write %b%b, want %b%b", want.word,
                               retireIllegal, retireWrite, want.illegal, want.write));
         if (want.write && {retireReg, retireData} !== {want.dest, want.data})
            mismatch($sformatf("instr %h wrote r%0d=%h, want r%0d=%h", want.word,
                               retireReg, retireData, want.dest, want.data));
      end
   end

   // end of run, anything still queued was lost
   task automatic flagLeftovers();
      while (expQ.size() != 0) begin
         errorCount++;
         $display("instruction %h issued at edge %0d never retired", expQ[0].word, expQ[0].cycle);
         expQ.delete(0);
      end
      pendingCount = 0;
   endtask

endmodule

`default_nettype wire

/* tbCore.sv */
// drives directed and seeded random streams on falling edges with one instr per cycle and no back-pressure
`default_nettype none
`timescale 1ns/1ns

`include "wiscCore_defines.svh"

module tbCore;

   logic                      clk;
   logic                      rst;
   logic [`WORD_WIDTH-1:0]    instr;
   logic                      instrValid;
   logic                      retireValid;
   logic                      retireIllegal;
   logic                      retireWrite;
   logic [`REG_SEL_WIDTH-1:0] retireReg;
   logic [`WORD_WIDTH-1:0]    retireData;
   int                        errorCount;
   int                        checkCount;
   int                        pendingCount; // records still in flight
   int                        timeouts;
   int unsigned               seed = 32'h7812_d2ec;

   cpuCore dut (.*);
   tbChecker chk (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk; // 8 ns period
   end

   // sampled at the next rising edge
   task automatic issue(input logic [`WORD_WIDTH-1:0] word);
      @(negedge clk);
      instr      = word;
      instrValid = 1'b1;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         instr      = 16'($urandom); // junk in bubbles must be ignored
         instrValid = 1'b0;
      end
   endtask

   // rs = 1 and rt = 2 compared both ways so the reads of r2 and r1 need forwarding
   task automatic comparePair(input logic [7:0] a, input logic [7:0] b);
      issue({isaPkg::opLbi, 3'd1, a});
      issue({isaPkg::opLbi, 3'd2, b});
      issue({isaPkg::opSeq, 3'd1, 3'd2, 3'd3, 2'b00});
      issue({isaPkg::opSlt, 3'd1, 3'd2, 3'd4, 2'b00});
      issue({isaPkg::opSle, 3'd1, 3'd2, 3'd5, 2'b00});
      issue({isaPkg::opSlt, 3'd2, 3'd1, 3'd6, 2'b00});
      issue({isaPkg::opSle, 3'd2, 3'd1, 3'd7, 2'b00});
   endtask

   initial begin
      logic [2:0] dst;
      logic [2:0] prev;
      logic [2:0] prev2;
      int         kind;
      int         waitCycles;
      void'($urandom(seed));
      rst        = 1'b1;
      instr      = '0;
      instrValid = 1'b0;
      timeouts   = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      idle(3); // nothing may retire straight out of reset
      // LBI everywhere with odd regs negative then BTR and SLBI on them
      for (int r = 0; r < `NUM_REGS; r++)
         issue({isaPkg::opLbi, 3'(r), r[0], 7'($urandom)});
      for (int r = 0; r < `NUM_REGS; r++) begin
         issue({isaPkg::opBtr, 3'(r), 3'($urandom), 3'(r + 5), 2'b00});
         issue({isaPkg::opSlbi, 3'(r), 8'($urandom)});
      end
      idle(2);
      // random RR and imm5 arithmetic over all registers
      for (int i = 0; i < 60; i++) begin
         kind = $urandom_range(0, 7);
         if (kind < 4)
            issue({isaPkg::opRr, 9'($urandom), 2'(kind)}); // funct from kind
         else
            issue({3'b010, 2'(kind - 4), 11'($urandom)}); // ADDI SUBI XORI ANDNI
      end
      idle(1);
      // signed compares with equal and mixed signs
      comparePair(8'd5, 8'd5);
      comparePair(8'hfd, 8'h04);
      comparePair(8'h04, 8'hfd);
      comparePair(8'hf9, 8'hf9);
      comparePair(8'hfe, 8'hf7);
      comparePair(8'h80, 8'h7f);
      // dependent chain where each reads the last two results with random gaps
      prev  = 3'd1;
      prev2 = 3'd2;
      for (int i = 0; i < 40; i++) begin
         dst = 3'($urandom);
         issue({isaPkg::opRr, prev, prev2, dst, 2'($urandom)});
         prev2 = prev;
         prev  = dst;
         if ($urandom_range(0, 3) == 0)
            idle($urandom_range(1, 2));
      end
      for (int i = 0; i < 8; i++) // r1 and r2 interleaved at distance two
         issue({isaPkg::opAddi, 3'(1 + i % 2), 3'(1 + i % 2), i[0] ? 5'h1f : 5'd3});
      // 00001 is NOP and every other 00xxx opcode is illegal
      issue({isaPkg::opNop, 11'($urandom)});
      for (int i = 0; i < 24; i++)
         issue({2'b00, 3'($urandom), 11'($urandom)});
      for (int r = 0; r < `NUM_REGS; r++)
         issue({isaPkg::opXori, 3'(r), 3'(r), 5'd0}); // read back expecting the value unchanged
      idle(4);
      waitCycles = 0;
      while (pendingCount != 0 && waitCycles < 20) begin
         @(negedge clk);
         waitCycles++;
      end
      if (pendingCount != 0) begin
         timeouts++;
         $display("timed out after %0d cycles with %0d retires missing",
                  waitCycles, pendingCount);
      end
      chk.flagLeftovers();
      $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeouts);
      if (errorCount == 0 && timeouts == 0 && checkCount > 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* wiscCore_defines.svh */
// core sizes for the 16-bit ISA where REG_SEL_WIDTH has to equal log2 of NUM_REGS
`ifndef WISCCORE_DEFINES_SVH
`define WISCCORE_DEFINES_SVH

// datapath and register width, also the instruction width
`define WORD_WIDTH 16

// r0..r7, r0 is writable like any other register
`define NUM_REGS 8

// width of the rs, rt and rd fields
`define REG_SEL_WIDTH 3

`endif

/* writeback.sv */
// purely combinational and the retire record is valid only while stageValid is high
`default_nettype none
`timescale 1ns/1ns

`include "wiscCore_defines.svh"

module writeback (
   input  logic                      stageValid,
   input  ctrlPkg::result_t          stageIn,
   output logic                      writeEn,
   output logic [`REG_SEL_WIDTH-1:0] writeSel,
   output logic [`WORD_WIDTH-1:0]    writeData,
   output logic                      retireValid,
   output logic                      retireIllegal,
   output logic                      retireWrite,
   output logic [`REG_SEL_WIDTH-1:0] retireReg,
   output logic [`WORD_WIDTH-1:0]    retireData
);

   assign writeEn   = stageValid && stageIn.regWrite; // bubbles never write
   assign writeSel  = stageIn.destSel;
   assign writeData = stageIn.value; // commits at the next edge

   // retire record mirrors the write
   assign retireValid   = stageValid;
   assign retireIllegal = stageValid && stageIn.illegal;
   assign retireWrite   = writeEn;
   assign retireReg     = stageIn.destSel;
   assign retireData    = stageIn.value;

   // decode has to drop regWrite for every opcode it flags
   always_comb begin
      illegalNoWrite: assert #0 (!(retireIllegal && retireWrite))
         else $error("illegal instruction retired with a register write");
   end

endmodule

`default_nettype wire
